/* design/cu_params.svh */
`ifndef CU_PARAMS_SVH
`define CU_PARAMS_SVH

// Bus and counter widths
`define CU_ADDR_W 64
`define CU_SIZE_W 32
`define CU_TAG_W 8

// Width of a granule shift amount
`define CU_SHIFT_W 5

// Stream 0 reads the send array
// Stream 1 writes the receive array
`define CU_NUM_STREAMS 2

// Granule sizes in bytes
`define CU_LINE_BYTES 128
`define CU_PAGE_BYTES 4096

// log2 of the granule sizes
`define CU_LINE_SHIFT 7
`define CU_PAGE_SHIFT 12

`endif

/* design/cu_pkg.sv */
`default_nettype none

`include "cu_params.svh"

package cu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Host side job description
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                  valid;
		logic [`CU_ADDR_W-1:0] send_base;
		logic [`CU_SIZE_W-1:0] send_size;
		logic [`CU_ADDR_W-1:0] recv_base;
		logic [`CU_SIZE_W-1:0] recv_size;
	} cu_wed_t;

	// One bit per stream in each field, stream 0 in bit 0
	typedef struct packed {
		logic [31-3*`CU_NUM_STREAMS:0] reserved;
		logic [`CU_NUM_STREAMS-1:0]    hint;
		logic [`CU_NUM_STREAMS-1:0]    page;
		logic [`CU_NUM_STREAMS-1:0]    enable;
	} cu_config_t;

	//////////////////////////////////////////////////////////////////////
	// Command encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic {
		cmd_read,
		cmd_write
	} cu_cmd_kind_e;

	// Coherence hint carried with each command
	typedef enum logic [1:0] {
		touch_i,
		touch_s,
		touch_m
	} cu_hint_e;

	//////////////////////////////////////////////////////////////////////
	// Per stream work and traffic
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                   active;
		logic [`CU_ADDR_W-1:0]  base;
		logic [`CU_SHIFT_W-1:0] shift;
		logic [`CU_SIZE_W-1:0]  total;
		cu_cmd_kind_e           kind;
		cu_hint_e               hint;
	} cu_stream_job_t;

	typedef struct packed {
		logic                  valid;
		cu_cmd_kind_e          kind;
		cu_hint_e              hint;
		logic [`CU_ADDR_W-1:0] addr;
		logic [`CU_TAG_W-1:0]  tag;
	} cu_cmd_t;

	typedef struct packed {
		logic                 valid;
		logic [`CU_TAG_W-1:0] tag;
	} cu_rsp_t;

endpackage

`default_nettype wire

/* design/cu_job_setup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_params.svh"

module cu_job_setup (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  cu_pkg::cu_wed_t        wed,
	input  cu_pkg::cu_config_t     cu_configure,
	output cu_pkg::cu_stream_job_t job [`CU_NUM_STREAMS]
);

	import cu_pkg::*;

	logic [`CU_ADDR_W-1:0] base [`CU_NUM_STREAMS];
	logic [`CU_SIZE_W-1:0] size [`CU_NUM_STREAMS];
	cu_stream_job_t        next_job [`CU_NUM_STREAMS];

	// Stream 0 walks the send array, stream 1 the receive array
	assign base[0] = wed.send_base;
	assign size[0] = wed.send_size;
	assign base[1] = wed.recv_base;
	assign size[1] = wed.recv_size;

	////////////////////////////////////////////////////////////////////
	// Job derivation
	////////////////////////////////////////////////////////////////////

	always_comb begin
		// One spare bit so a size close to 4G does not wrap when rounded
		logic [`CU_SIZE_W:0] rounded;

		rounded = '0;
		for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
			// An all zero configuration has no enable bit and starts nothing
			next_job[s].active = wed.valid && cu_configure.enable[s];
			next_job[s].base   = base[s];

			if (cu_configure.page[s]) begin
				next_job[s].shift = `CU_SHIFT_W'(`CU_PAGE_SHIFT);
				rounded = {1'b0, size[s]} + (`CU_SIZE_W+1)'(`CU_PAGE_BYTES - 1);
			end else begin
				next_job[s].shift = `CU_SHIFT_W'(`CU_LINE_SHIFT);
				rounded = {1'b0, size[s]} + (`CU_SIZE_W+1)'(`CU_LINE_BYTES - 1);
			end
			next_job[s].total = `CU_SIZE_W'(rounded >> next_job[s].shift);

			// Read side shares the line, write side wants ownership
			if (s == 0) begin
				next_job[s].kind = cmd_read;
				next_job[s].hint = cu_configure.hint[s] ? touch_s : touch_i;
			end else begin
				next_job[s].kind = cmd_write;
				next_job[s].hint = cu_configure.hint[s] ? touch_m : touch_i;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Job registers
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
				job[s] <= '0;
			end
		end else begin
			if (enabled) begin
				for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
					job[s] <= next_job[s];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/cu_stream_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_params.svh"

module cu_stream_engine (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  cu_pkg::cu_stream_job_t job,
	input  logic                   full,
	input  cu_pkg::cu_rsp_t        response,
	output cu_pkg::cu_cmd_t        command,
	output logic                   issued_all,
	output logic [`CU_SIZE_W-1:0]  completed
);

	import cu_pkg::*;

	logic                  active_q;
	logic                  start;
	logic                  issue;
	logic [`CU_SIZE_W-1:0] index;
	logic [`CU_ADDR_W-1:0] addr;
	logic [`CU_ADDR_W-1:0] stride;

	// Command register fields
	logic                  cmd_valid;
	cu_cmd_kind_e          cmd_kind;
	cu_hint_e              cmd_hint;
	logic [`CU_ADDR_W-1:0] cmd_addr;
	logic [`CU_TAG_W-1:0]  cmd_tag;

	// Rising edge of active loads the counters
	assign start = job.active && !active_q;

	// Counters are valid from the cycle after the load
	assign issue = active_q && job.active && (index < job.total) && !full;

	assign stride = `CU_ADDR_W'(1) << job.shift;

	// Zero sized stream is complete as soon as it is loaded
	assign issued_all = active_q && (index == job.total);

	////////////////////////////////////////////////////////////////////
	// Issue index and address walk
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active_q  <= 1'b0;
			index     <= '0;
			addr      <= '0;
			cmd_valid <= 1'b0;
		end else begin
			if (enabled) begin
				active_q  <= job.active;
				cmd_valid <= issue;
				if (start) begin
					index <= '0;
					addr  <= job.base;
				end else if (issue) begin
					index <= index + 1'b1;
					addr  <= addr + stride;
				end
			end
		end
	end

	// Payload keeps the last issued command
	always_ff @(posedge clock) begin
		if (enabled && issue) begin
			cmd_kind <= job.kind;
			cmd_hint <= job.hint;
			cmd_addr <= addr;
			cmd_tag  <= index[`CU_TAG_W-1:0];
		end
	end

	assign command = '{
		valid: cmd_valid,
		kind:  cmd_kind,
		hint:  cmd_hint,
		addr:  cmd_addr,
		tag:   cmd_tag
	};

	////////////////////////////////////////////////////////////////////
	// Response counter
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			completed <= '0;
		end else begin
			if (enabled) begin
				if (start) begin
					completed <= '0;
				end else if (active_q && job.active && response.valid) begin
					completed <= completed + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/cu_completion.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_params.svh"

module cu_completion (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  cu_pkg::cu_stream_job_t     job [`CU_NUM_STREAMS],
	input  logic [`CU_NUM_STREAMS-1:0] issued_all,
	input  logic [`CU_SIZE_W-1:0]      completed [`CU_NUM_STREAMS],
	output logic                       cu_done,
	output logic [`CU_SIZE_W-1:0]      cu_return
);

	import cu_pkg::*;

	logic                  any_active;
	logic                  all_done;
	logic [`CU_SIZE_W-1:0] return_sel;

	////////////////////////////////////////////////////////////////////
	// Done detection and return select
	////////////////////////////////////////////////////////////////////

	always_comb begin
		any_active = 1'b0;
		all_done   = 1'b1;
		return_sel = completed[0];
		for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
			if (job[s].active) begin
				any_active = 1'b1;
				// issued_all also masks counts left over from the previous job
				if (!issued_all[s] || (completed[s] != job[s].total)) begin
					all_done = 1'b0;
				end
				// Write stream count wins when it runs
				if (s > 0) begin
					return_sel = completed[s];
				end
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_done   <= 1'b0;
			cu_return <= '0;
		end else begin
			if (enabled) begin
				cu_done   <= any_active && all_done;
				cu_return <= return_sel;
			end
		end
	end

endmodule

`default_nettype wire

/* design/cu_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_params.svh"

module cu_control (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  cu_pkg::cu_wed_t            wed,
	input  cu_pkg::cu_config_t         cu_configure,
	input  logic [`CU_NUM_STREAMS-1:0] buffer_full,
	input  cu_pkg::cu_rsp_t            response [`CU_NUM_STREAMS],
	output cu_pkg::cu_cmd_t            command [`CU_NUM_STREAMS],
	output logic                       cu_done,
	output logic [`CU_SIZE_W-1:0]      cu_return
);

	import cu_pkg::*;

	cu_wed_t                    wed_q;
	cu_config_t                 cfg_q;
	cu_rsp_t                    response_q [`CU_NUM_STREAMS];
	cu_stream_job_t             job [`CU_NUM_STREAMS];
	logic [`CU_NUM_STREAMS-1:0] issued_all;
	logic [`CU_SIZE_W-1:0]      completed [`CU_NUM_STREAMS];

	//////////////////////////////////////////////////////////////////////
	// Input registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_q <= '0;
			cfg_q <= '0;
			for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
				response_q[s] <= '0;
			end
		end else begin
			if (enabled) begin
				wed_q <= wed;
				// Keep the last non-zero configuration
				if (|cu_configure) begin
					cfg_q <= cu_configure;
				end
				for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
					response_q[s] <= response[s];
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Job setup, stream engines and completion
	//////////////////////////////////////////////////////////////////////

	cu_job_setup u_job_setup (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.wed         (wed_q),
		.cu_configure(cfg_q),
		.job         (job)
	);

	for (genvar s = 0; s < `CU_NUM_STREAMS; s++) begin : g_stream
		cu_stream_engine u_engine (
			.clock     (clock),
			.rstn      (rstn),
			.enabled   (enabled),
			.job       (job[s]),
			.full      (buffer_full[s]),
			.response  (response_q[s]),
			.command   (command[s]),
			.issued_all(issued_all[s]),
			.completed (completed[s])
		);
	end

	cu_completion u_completion (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.job       (job),
		.issued_all(issued_all),
		.completed (completed),
		.cu_done   (cu_done),
		.cu_return (cu_return)
	);

endmodule

`default_nettype wire

/* bench/cu_tb_table.svh */
`ifndef CU_TB_TABLE_SVH
`define CU_TB_TABLE_SVH

// One job per row, applied in order
typedef struct packed {
	cu_config_t            cfg;
	logic [`CU_ADDR_W-1:0] send_base;
	logic [`CU_SIZE_W-1:0] send_size;
	logic [`CU_ADDR_W-1:0] recv_base;
	logic [`CU_SIZE_W-1:0] recv_size;
	int                    full_pct;
	int                    send_cmds;
	int                    recv_cmds;
	int                    ret;
} row_t;

localparam int NUM_ROWS = 8;

// cfg, send base, send size, recv base, recv size, buffer_full percent,
// expected send commands, expected recv commands, expected cu_return
// cfg bits [1:0] enable, [3:2] page granule, [5:4] hint, stream 0 in the low bit
row_t job_rows [NUM_ROWS] = '{
	'{32'h00, 64'h10_0000, 32'd1024, 64'h20_0000, 32'd1024, 0, 0, 0, 0},
	'{32'h11, 64'h10_0000, 32'd1000, 64'h20_0000, 32'd512, 0, 8, 0, 8},
	'{32'h2A, 64'h30_0000, 32'd64, 64'h7f00_0000_0000, 32'd20481, 0, 0, 6, 6},
	'{32'h0B, 64'h40_0080, 32'd5120, 64'h50_0000, 32'd12288, 40, 40, 3, 3},
	'{32'h33, 64'h60_0000, 32'd38400, 64'h70_0000, 32'd129, 25, 300, 2, 2},
	'{32'h13, 64'h80_0000, 32'd0, 64'h90_0000, 32'd640, 10, 0, 5, 5},
	'{32'h07, 64'hA0_0000, 32'd8197, 64'hB0_0000, 32'd0, 50, 3, 0, 0},
	// Empty read stream alone
	'{32'h01, 64'hC0_0000, 32'd0, 64'hD0_0000, 32'd256, 0, 0, 0, 0}
};

`endif

/* bench/cu_control_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_params.svh"

module cu_control_tb;

	import cu_pkg::*;

	`include "cu_tb_table.svh"

	logic                       clock;
	logic                       rstn;
	logic                       enabled;
	cu_wed_t                    wed;
	cu_config_t                 cu_configure;
	logic [`CU_NUM_STREAMS-1:0] buffer_full;
	cu_rsp_t                    response [`CU_NUM_STREAMS];
	cu_cmd_t                    command [`CU_NUM_STREAMS];
	logic                       cu_done;
	logic [`CU_SIZE_W-1:0]      cu_return;

	// Checker and response model state
	row_t                       cur;
	int                         cycle_count;
	int                         row_start;
	int                         issued [`CU_NUM_STREAMS];
	int                         delivered [`CU_NUM_STREAMS];
	int                         exp_cmds [`CU_NUM_STREAMS];
	logic [`CU_NUM_STREAMS-1:0] prev_full;
	int                         due_q [`CU_NUM_STREAMS][$];
	logic [`CU_TAG_W-1:0]       tag_q [`CU_NUM_STREAMS][$];

	cu_control dut (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.wed         (wed),
		.cu_configure(cu_configure),
		.buffer_full (buffer_full),
		.response    (response),
		.command     (command),
		.cu_done     (cu_done),
		.cu_return   (cu_return)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Error reporting and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_cmd(input string name, input cu_cmd_t got, input cu_cmd_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_done(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_return(input string name, input logic [`CU_SIZE_W-1:0] got,
			input logic [`CU_SIZE_W-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Command number index of stream s for the current row
	function automatic cu_cmd_t expected_command(input int s, input int index);
		cu_cmd_t               c;
		logic [`CU_ADDR_W-1:0] gran;
		logic [`CU_ADDR_W-1:0] base;

		gran = cur.cfg.page[s] ? `CU_ADDR_W'(`CU_PAGE_BYTES) : `CU_ADDR_W'(`CU_LINE_BYTES);
		c.valid = 1'b1;
		if (s == 0) begin
			c.kind = cmd_read;
			c.hint = cur.cfg.hint[s] ? touch_s : touch_i;
			base   = cur.send_base;
		end else begin
			c.kind = cmd_write;
			c.hint = cur.cfg.hint[s] ? touch_m : touch_i;
			base   = cur.recv_base;
		end
		c.addr = base + `CU_ADDR_W'(index) * gran;
		c.tag  = `CU_TAG_W'(index % 256);
		return c;
	endfunction

	function automatic logic responses_complete();
		logic ok;

		ok = 1'b1;
		for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
			if (delivered[s] != exp_cmds[s]) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	// One clock cycle of monitoring and driving on the falling edge
	task automatic next_cycle();
		cu_rsp_t                    rsp;
		logic [`CU_NUM_STREAMS-1:0] full_now;
		string                      name;

		@(negedge clock);
		cycle_count++;
		for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
			name = $sformatf("command[%0d]", s);
			if (command[s].valid === 1'b1) begin
				if (prev_full[s]) begin
					abort_run($sformatf("stream %0d issued a command while its buffer was full", s));
				end else if (issued[s] >= exp_cmds[s]) begin
					abort_run($sformatf("stream %0d issued more commands than its job holds", s));
				end else begin
					// Three cycles after the sampling edge is the fourth falling edge
					if (issued[s] == 0 && cur.full_pct == 0) begin
						check_return({name, " first cycle"},
							`CU_SIZE_W'(cycle_count - row_start), `CU_SIZE_W'(4));
					end
					check_cmd(name, command[s], expected_command(s, issued[s]));
					due_q[s].push_back(cycle_count + int'($urandom_range(4, 1)));
					tag_q[s].push_back(command[s].tag);
					issued[s]++;
				end
			end
		end

		if (cu_done === 1'b1) begin
			check_done("cu_done", cu_done, responses_complete());
		end

		// At most one response strobe per stream and cycle
		for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
			rsp = '0;
			if (due_q[s].size() > 0 && due_q[s][0] <= cycle_count) begin
				rsp.valid = 1'b1;
				rsp.tag   = tag_q[s].pop_front();
				void'(due_q[s].pop_front());
				delivered[s]++;
			end
			response[s] = rsp;
			full_now[s] = int'($urandom_range(99)) < cur.full_pct;
		end
		buffer_full = full_now;
		prev_full   = full_now;
	endtask

	task automatic apply_row(input int r);
		int waited;

		cur         = job_rows[r];
		exp_cmds[0] = cur.send_cmds;
		exp_cmds[1] = cur.recv_cmds;
		for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
			issued[s]    = 0;
			delivered[s] = 0;
			due_q[s].delete();
			tag_q[s].delete();
		end
		wed = '{valid: 1'b1, send_base: cur.send_base, send_size: cur.send_size,
			recv_base: cur.recv_base, recv_size: cur.recv_size};
		cu_configure = cur.cfg;
		buffer_full  = '0;
		prev_full    = '0;
		row_start    = cycle_count;

		if (cur.cfg == '0) begin
			// Ignored configuration leaves the unit idle
			repeat (24) begin
				next_cycle();
				check_done("cu_done", cu_done, 1'b0);
			end
		end else begin
			while (cu_done !== 1'b1) begin
				next_cycle();
			end
			for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
				check_return($sformatf("issued count of stream %0d", s),
					`CU_SIZE_W'(issued[s]), `CU_SIZE_W'(exp_cmds[s]));
			end
			check_return("cu_return", cu_return, `CU_SIZE_W'(cur.ret));
			repeat (3) begin
				next_cycle();
				check_done("cu_done", cu_done, 1'b1);
			end
		end

		wed.valid = 1'b0;
		waited    = 0;
		while (cu_done !== 1'b0) begin
			if (waited == 3) begin
				abort_run("cu_done stayed high after the job descriptor was withdrawn");
			end else begin
				next_cycle();
				waited++;
			end
		end
		repeat (2) next_cycle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h997c));
		rstn         = 1'b0;
		enabled      = 1'b0;
		wed          = '0;
		cu_configure = '0;
		buffer_full  = '0;
		prev_full    = '0;
		cur          = '0;
		cycle_count  = 0;
		row_start    = 0;
		for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
			response[s]  = '0;
			issued[s]    = 0;
			delivered[s] = 0;
			exp_cmds[s]  = 0;
		end

		repeat (5) @(posedge clock);
		@(negedge clock);
		rstn    = 1'b1;
		enabled = 1'b1;

		for (int s = 0; s < `CU_NUM_STREAMS; s++) begin
			check_done($sformatf("command[%0d].valid", s), command[s].valid, 1'b0);
		end
		check_done("cu_done", cu_done, 1'b0);
		check_return("cu_return", cu_return, '0);

		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_row(r);
		end

		$display("TEST PASSED");
		$finish;
	end

	initial begin
		int cycle_limit;

		@(posedge rstn);
		cycle_limit = 20;
		for (int r = 0; r < NUM_ROWS; r++) begin
			cycle_limit += (job_rows[r].send_cmds + job_rows[r].recv_cmds) * 10 + 200;
		end
		repeat (cycle_limit) @(posedge clock);
		$display("timeout after %0d cycles without finishing all jobs", cycle_limit);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
+incdir+bench
design/cu_pkg.sv
design/cu_job_setup.sv
design/cu_stream_engine.sv
design/cu_completion.sv
design/cu_control.sv
bench/cu_control_tb.sv

/* Makefile */
# Verilator build and run for the stream accelerator control unit

VERILATOR ?= verilator
TOP       ?= cu_control_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard design/*.svh bench/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, not the simulator exit code
run: $(SIM)
	@$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^TEST PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
